//--- axis_if.sv
`timescale 1ns/1ps

// beat stream between a data queue and the packet arbiter
interface axis_if;
  logic                             tvalid;
  logic                             tready;
  logic [stream_pkg::data_bits-1:0] tdata;
  logic [stream_pkg::keep_bits-1:0] tkeep;  // passed through untouched
  logic                             tlast;

  modport src (output tvalid, tdata, tkeep, tlast, input tready);
  modport snk (input tvalid, tdata, tkeep, tlast, output tready);
endinterface

//--- cred_gate.sv
`timescale 1ns/1ps

module cred_gate (
  input  logic aclk,
  input  logic arst_n,
  req_if.snk   s_req,
  req_if.src   m_req,
  input  logic xfer    // a beat entered this destination's data queue
);

  logic [stream_pkg::beat_cnt_bits-1:0] cred;      // buffered beats that no packet has claimed
  logic [stream_pkg::beat_cnt_bits-1:0] cred_nxt;
  logic [stream_pkg::beat_cnt_bits-1:0] beats;     // beats the waiting packet needs
  logic                                 round_up;
  logic                                 covered;
  logic                                 take;

  // byte length divided by beat size with a partial beat counted as a whole one
  assign round_up = |s_req.len[$clog2(stream_pkg::beat_bytes)-1:0];
  assign beats    = s_req.len[$clog2(stream_pkg::beat_bytes) +: stream_pkg::beat_cnt_bits]
                  + {{(stream_pkg::beat_cnt_bits - 1){1'b0}}, round_up};

  // the packet is offered only once every one of its beats sits in the data queue
  assign covered     = (cred >= beats);
  assign m_req.valid = s_req.valid && covered;
  assign m_req.addr  = s_req.addr;
  assign m_req.len   = s_req.len;
  assign m_req.dest  = s_req.dest;
  assign s_req.ready = m_req.ready && covered;
  assign take        = m_req.valid && m_req.ready;

  always_comb begin
    cred_nxt = cred;
    if (xfer) cred_nxt = cred_nxt + 1'b1;
    if (take) cred_nxt = cred_nxt - beats;  // the leaving packet claims its beats
  end

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) cred <= '0;
    else cred <= cred_nxt;
  end

  // unclaimed beats can never exceed what the data queue holds, and a wrap below zero would
  assert property (@(posedge aclk) disable iff (!arst_n)
    cred <= cred_pkg::data_qdepth);

endmodule

//--- cred_pkg.sv
package cred_pkg;

  // --------------------------------------------------------------------------
  // request side of the host write path
  // --------------------------------------------------------------------------
  localparam int n_dests   = 2;   // destination queues behind the host port
  localparam int dest_bits = 1;   // wide enough to index every destination
  localparam int addr_bits = 48;  // host address carried by each request
  localparam int len_bits  = 16;  // byte length of one host request

  // largest packet the split engine hands to a destination
  localparam int pmtu_bytes = 256;

  // --------------------------------------------------------------------------
  // buffering
  // --------------------------------------------------------------------------
  localparam int req_qdepth   = 4;   // host requests waiting for the split engine
  localparam int data_qdepth  = 64;  // beats per destination and enough for one full packet
  localparam int grant_qdepth = 4;   // packets granted and not yet fully streamed

endpackage

//--- data_queue.sv
`timescale 1ns/1ps

module data_queue (
  input  logic                             aclk,
  input  logic                             arst_n,
  input  logic                             s_tvalid,
  output logic                             s_tready,
  input  logic [stream_pkg::data_bits-1:0] s_tdata,
  input  logic [stream_pkg::keep_bits-1:0] s_tkeep,
  axis_if.src                              m_axis,
  output logic                             xfer      // one pulse per accepted beat
);

  logic [stream_pkg::data_bits-1:0]             mem_data [cred_pkg::data_qdepth];
  logic [stream_pkg::keep_bits-1:0]             mem_keep [cred_pkg::data_qdepth];
  logic [$clog2(cred_pkg::data_qdepth)-1:0]     wr_ptr;
  logic [$clog2(cred_pkg::data_qdepth)-1:0]     rd_ptr;
  logic [$clog2(cred_pkg::data_qdepth + 1)-1:0] count;  // beats held right now
  logic                                         run;
  logic                                         full;
  logic                                         rd_en;

  assign full     = (count == cred_pkg::data_qdepth);
  assign s_tready = run && !full;      // low through reset and until the queue has room
  assign xfer     = s_tvalid && s_tready;
  assign rd_en    = m_axis.tvalid && m_axis.tready;

  // the head entry is visible the cycle after it was written
  assign m_axis.tvalid = (count != 0);
  assign m_axis.tdata  = mem_data[rd_ptr];
  assign m_axis.tkeep  = mem_keep[rd_ptr];
  assign m_axis.tlast  = 1'b0;         // packet boundaries come from the arbiter

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      run    <= 1'b0;
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      run <= 1'b1;
      if (xfer) wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two so the pointers wrap
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      if (xfer && !rd_en) count <= count + 1'b1;
      else if (rd_en && !xfer) count <= count - 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (xfer) begin
      mem_data[wr_ptr] <= s_tdata;
      mem_keep[wr_ptr] <= s_tkeep;
    end
  end

  // a write never lands on the entry that is still waiting at the head
  assert property (@(posedge aclk) disable iff (!arst_n)
    (xfer && (count != 0)) |-> (wr_ptr != rd_ptr));

endmodule

//--- host_wr_credits.sv
`timescale 1ns/1ps

module host_wr_credits (
  input  logic                             aclk,
  input  logic                             arst_n,
  // host write requests
  input  logic                             req_valid,
  output logic                             req_ready,
  input  logic [cred_pkg::addr_bits-1:0]   req_addr,
  input  logic [cred_pkg::len_bits-1:0]    req_len,
  input  logic [cred_pkg::dest_bits-1:0]   req_dest,
  // one data stream per destination
  input  logic                             s_tvalid [cred_pkg::n_dests],
  output logic                             s_tready [cred_pkg::n_dests],
  input  logic [stream_pkg::data_bits-1:0] s_tdata  [cred_pkg::n_dests],
  input  logic [stream_pkg::keep_bits-1:0] s_tkeep  [cred_pkg::n_dests],
  // outgoing packet requests and the shared data stream
  output logic                             m_req_valid,
  input  logic                             m_req_ready,
  output logic [cred_pkg::addr_bits-1:0]   m_req_addr,
  output logic [cred_pkg::len_bits-1:0]    m_req_len,
  output logic [cred_pkg::dest_bits-1:0]   m_req_dest,
  output logic                             m_tvalid,
  input  logic                             m_tready,
  output logic [stream_pkg::data_bits-1:0] m_tdata,
  output logic [stream_pkg::keep_bits-1:0] m_tkeep,
  output logic                             m_tlast
);

  req_if  host_req ();
  req_if  parsed [cred_pkg::n_dests] ();  // parser to gate
  req_if  gated  [cred_pkg::n_dests] ();  // gate to arbiter
  axis_if dq     [cred_pkg::n_dests] ();  // data queue to arbiter
  logic [cred_pkg::n_dests-1:0] xfer;

  assign host_req.valid = req_valid;
  assign host_req.addr  = req_addr;
  assign host_req.len   = req_len;
  assign host_req.dest  = req_dest;
  assign req_ready      = host_req.ready;

  req_parser inst_parser (.aclk(aclk), .arst_n(arst_n), .s_req(host_req), .m_req(parsed));

  for (genvar i = 0; i < cred_pkg::n_dests; i++) begin : g_dest
    data_queue inst_dq (
      .aclk    (aclk),
      .arst_n  (arst_n),
      .s_tvalid(s_tvalid[i]),
      .s_tready(s_tready[i]),
      .s_tdata (s_tdata[i]),
      .s_tkeep (s_tkeep[i]),
      .m_axis  (dq[i]),
      .xfer    (xfer[i])
    );

    cred_gate inst_gate (
      .aclk(aclk), .arst_n(arst_n), .s_req(parsed[i]), .m_req(gated[i]), .xfer(xfer[i])
    );
  end

  pkt_arbiter inst_arb (
    .aclk       (aclk),
    .arst_n     (arst_n),
    .s_req      (gated),
    .s_axis     (dq),
    .m_req_valid(m_req_valid),
    .m_req_ready(m_req_ready),
    .m_req_addr (m_req_addr),
    .m_req_len  (m_req_len),
    .m_req_dest (m_req_dest),
    .m_tvalid   (m_tvalid),
    .m_tready   (m_tready),
    .m_tdata    (m_tdata),
    .m_tkeep    (m_tkeep),
    .m_tlast    (m_tlast)
  );

endmodule

//--- pkt_arbiter.sv
`timescale 1ns/1ps

module pkt_arbiter (
  input  logic                             aclk,
  input  logic                             arst_n,
  req_if.snk                               s_req  [cred_pkg::n_dests],
  axis_if.snk                              s_axis [cred_pkg::n_dests],
  output logic                             m_req_valid,
  input  logic                             m_req_ready,
  output logic [cred_pkg::addr_bits-1:0]   m_req_addr,
  output logic [cred_pkg::len_bits-1:0]    m_req_len,
  output logic [cred_pkg::dest_bits-1:0]   m_req_dest,
  output logic                             m_tvalid,
  input  logic                             m_tready,
  output logic [stream_pkg::data_bits-1:0] m_tdata,
  output logic [stream_pkg::keep_bits-1:0] m_tkeep,
  output logic                             m_tlast
);

  // flat copies of the interface arrays so that they can be indexed by a signal
  logic [cred_pkg::n_dests-1:0]     req_vld;
  logic [cred_pkg::addr_bits-1:0]   req_addr [cred_pkg::n_dests];
  logic [cred_pkg::len_bits-1:0]    req_len  [cred_pkg::n_dests];
  logic [cred_pkg::dest_bits-1:0]   req_dest [cred_pkg::n_dests];
  logic [cred_pkg::n_dests-1:0]     ax_vld;
  logic [stream_pkg::data_bits-1:0] ax_data  [cred_pkg::n_dests];
  logic [stream_pkg::keep_bits-1:0] ax_keep  [cred_pkg::n_dests];

  logic [cred_pkg::dest_bits-1:0]     last_win;   // the winner before gets lowest priority
  logic [cred_pkg::dest_bits-1:0]     win;
  logic                               any;
  logic                               grant;
  logic [cred_pkg::len_bits-1:0]      win_len;
  logic [stream_pkg::beat_cnt_bits-1:0] win_beats;

  // --------------------------------------------------------------------------
  // grant queue of packets in flight, oldest at gq_rd
  // --------------------------------------------------------------------------
  logic [cred_pkg::dest_bits-1:0]               gq_dest  [cred_pkg::grant_qdepth];
  logic [stream_pkg::beat_cnt_bits-1:0]         gq_beats [cred_pkg::grant_qdepth];
  logic [$clog2(cred_pkg::grant_qdepth)-1:0]     gq_wr;
  logic [$clog2(cred_pkg::grant_qdepth)-1:0]     gq_rd;
  logic [$clog2(cred_pkg::grant_qdepth + 1)-1:0] gq_cnt;
  logic [cred_pkg::dest_bits-1:0]               hd;          // destination now streaming
  logic [stream_pkg::beat_cnt_bits-1:0]         beat_cnt;    // beats of the head already sent
  logic                                         stream_ok;
  logic                                         beat;
  logic                                         pop;

  for (genvar i = 0; i < cred_pkg::n_dests; i++) begin : g_view
    assign req_vld[i]       = s_req[i].valid;
    assign req_addr[i]      = s_req[i].addr;
    assign req_len[i]       = s_req[i].len;
    assign req_dest[i]      = s_req[i].dest;
    assign s_req[i].ready   = grant && (win == i);
    assign ax_vld[i]        = s_axis[i].tvalid;
    assign ax_data[i]       = s_axis[i].tdata;
    assign ax_keep[i]       = s_axis[i].tkeep;
    assign s_axis[i].tready = stream_ok && (hd == i) && m_tready;
  end

  // round-robin search that starts just past the last winner
  always_comb begin
    int idx;
    win = last_win;
    any = 1'b0;
    for (int k = 1; k <= cred_pkg::n_dests; k++) begin
      idx = (int'(last_win) + k) % cred_pkg::n_dests;
      if (!any && req_vld[idx]) begin
        any = 1'b1;
        win = idx[cred_pkg::dest_bits-1:0];
      end
    end
  end

  // grant only when the request register frees up and the grant queue has room
  assign grant     = any && (gq_cnt != cred_pkg::grant_qdepth) && (!m_req_valid || m_req_ready);
  assign win_len   = req_len[win];
  assign win_beats = win_len[$clog2(stream_pkg::beat_bytes) +: stream_pkg::beat_cnt_bits]
                   + {{(stream_pkg::beat_cnt_bits - 1){1'b0}},
                      |win_len[$clog2(stream_pkg::beat_bytes)-1:0]};

  // the newest grant is still waiting in the request register while m_req_valid is high
  assign hd        = gq_dest[gq_rd];
  assign stream_ok = (gq_cnt > 1) || ((gq_cnt == 1) && !m_req_valid);
  assign m_tvalid  = stream_ok && ax_vld[hd];
  assign m_tdata   = ax_data[hd];
  assign m_tkeep   = ax_keep[hd];
  assign m_tlast   = m_tvalid && (beat_cnt == gq_beats[gq_rd] - 1'b1);
  assign beat      = m_tvalid && m_tready;
  assign pop       = beat && m_tlast;  // head packet done

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      last_win    <= '0;
      m_req_valid <= 1'b0;
      gq_wr       <= '0;
      gq_rd       <= '0;
      gq_cnt      <= '0;
      beat_cnt    <= '0;
    end else begin
      if (grant) last_win <= win;
      if (grant) m_req_valid <= 1'b1;
      else if (m_req_ready) m_req_valid <= 1'b0;
      if (grant) gq_wr <= gq_wr + 1'b1;
      if (pop) gq_rd <= gq_rd + 1'b1;
      if (grant && !pop) gq_cnt <= gq_cnt + 1'b1;
      else if (pop && !grant) gq_cnt <= gq_cnt - 1'b1;
      if (pop) beat_cnt <= '0;
      else if (beat) beat_cnt <= beat_cnt + 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (grant) begin
      m_req_addr      <= req_addr[win];  // offered the cycle after the grant
      m_req_len       <= win_len;
      m_req_dest      <= req_dest[win];
      gq_dest[gq_wr]  <= win;
      gq_beats[gq_wr] <= win_beats;
    end
  end

  // data only ever flows for a packet that holds a grant and still has beats to send
  assert property (@(posedge aclk) disable iff (!arst_n)
    m_tvalid |-> (gq_cnt != 0) && (beat_cnt < gq_beats[gq_rd]));

endmodule

//--- req_if.sv
`timescale 1ns/1ps

// one packet or host request, moved with a valid/ready handshake
interface req_if;
  logic                           valid;  // payload below is stable while this is high
  logic                           ready;
  logic [cred_pkg::addr_bits-1:0] addr;   // host address of the first byte
  logic [cred_pkg::len_bits-1:0]  len;    // byte count
  logic [cred_pkg::dest_bits-1:0] dest;   // destination queue index

  modport src (output valid, addr, len, dest, input ready);
  modport snk (input valid, addr, len, dest, output ready);
endinterface

//--- req_parser.sv
`timescale 1ns/1ps

module req_parser (
  input  logic aclk,
  input  logic arst_n,
  req_if.snk   s_req,
  req_if.src   m_req [cred_pkg::n_dests]
);

  // --------------------------------------------------------------------------
  // host request queue
  // --------------------------------------------------------------------------
  logic [cred_pkg::addr_bits-1:0]              q_addr [cred_pkg::req_qdepth];
  logic [cred_pkg::len_bits-1:0]               q_len  [cred_pkg::req_qdepth];
  logic [cred_pkg::dest_bits-1:0]              q_dest [cred_pkg::req_qdepth];
  logic [$clog2(cred_pkg::req_qdepth)-1:0]     wr_ptr;
  logic [$clog2(cred_pkg::req_qdepth)-1:0]     rd_ptr;
  logic [$clog2(cred_pkg::req_qdepth + 1)-1:0] q_cnt;
  logic                                        run;   // goes high one cycle out of reset
  logic                                        push;
  logic                                        load;

  // split engine state
  logic                           busy;      // a request is being cut into packets
  logic [cred_pkg::len_bits-1:0]  rem_len;   // bytes of the request not yet sent
  logic [cred_pkg::addr_bits-1:0] cur_addr;  // address of the next packet
  logic [cred_pkg::dest_bits-1:0] cur_dest;
  logic [cred_pkg::len_bits-1:0]  pkt_len;
  logic [cred_pkg::n_dests-1:0]   rdy_vec;
  logic                           take;

  assign s_req.ready = run && (q_cnt != cred_pkg::req_qdepth);
  assign push        = s_req.valid && s_req.ready;
  assign load        = !busy && (q_cnt != 0);  // the idle engine picks up the queue head

  // a full transfer unit while more than one remains, else the remainder
  assign pkt_len = (rem_len > cred_pkg::pmtu_bytes) ?
                   cred_pkg::pmtu_bytes[cred_pkg::len_bits-1:0] : rem_len;
  assign take    = busy && rdy_vec[cur_dest];

  // every port sees the same packet and only the one named by dest gets valid
  for (genvar i = 0; i < cred_pkg::n_dests; i++) begin : g_route
    assign m_req[i].valid = busy && (cur_dest == i);
    assign m_req[i].addr  = cur_addr;
    assign m_req[i].len   = pkt_len;
    assign m_req[i].dest  = cur_dest;
    assign rdy_vec[i]     = m_req[i].ready;
  end

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      run    <= 1'b0;
      wr_ptr <= '0;
      rd_ptr <= '0;
      q_cnt  <= '0;
      busy   <= 1'b0;
    end else begin
      run <= 1'b1;
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (load) rd_ptr <= rd_ptr + 1'b1;
      if (push && !load) q_cnt <= q_cnt + 1'b1;
      else if (load && !push) q_cnt <= q_cnt - 1'b1;
      if (load) busy <= 1'b1;
      else if (take && (rem_len <= cred_pkg::pmtu_bytes)) busy <= 1'b0;  // last piece gone
    end
  end

  always_ff @(posedge aclk) begin
    if (push) begin
      q_addr[wr_ptr] <= s_req.addr;
      q_len[wr_ptr]  <= s_req.len;
      q_dest[wr_ptr] <= s_req.dest;
    end
    if (load) begin
      rem_len  <= q_len[rd_ptr];
      cur_addr <= q_addr[rd_ptr];
      cur_dest <= q_dest[rd_ptr];
    end else if (take) begin
      rem_len  <= rem_len - pkt_len;
      cur_addr <= cur_addr + pkt_len;  // the next packet starts right after this one
    end
  end

  // the host must never hand in a zero length, and the cut never exceeds one transfer unit
  assert property (@(posedge aclk) disable iff (!arst_n)
    busy |-> (pkt_len != 0) && (pkt_len <= cred_pkg::pmtu_bytes));

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_host_wr -f sources.f || exit 1
out=$(./obj_dir/Vtb_host_wr)
echo "$out"
echo "$out" | grep -qx "No errors" && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- sources.f
cred_pkg.sv
stream_pkg.sv
req_if.sv
axis_if.sv
req_parser.sv
data_queue.sv
cred_gate.sv
pkt_arbiter.sv
host_wr_credits.sv
tb_checker.sv
tb_host_wr.sv

//--- stream_pkg.sv
package stream_pkg;

  // beat geometry of the data streams
  localparam int data_bits  = 64;  // payload bits per beat
  localparam int keep_bits  = 8;   // one tkeep bit for each payload byte
  localparam int beat_bytes = 8;   // bytes that one full beat covers

  // beat counts of one packet and of the credit counters fit in this width
  localparam int beat_cnt_bits = 8;

endpackage

//--- tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
  input  logic                             aclk, arst_n,
  input  logic                             req_valid, req_ready, m_req_valid, m_req_ready,
  input  logic                             m_tvalid, m_tready, m_tlast,
  input  logic [cred_pkg::addr_bits-1:0]   req_addr, m_req_addr,
  input  logic [cred_pkg::len_bits-1:0]    req_len, m_req_len,
  input  logic [cred_pkg::dest_bits-1:0]   req_dest, m_req_dest,
  input  logic                             s_tvalid [cred_pkg::n_dests],
  input  logic                             s_tready [cred_pkg::n_dests],
  input  logic [stream_pkg::data_bits-1:0] s_tdata  [cred_pkg::n_dests],
  input  logic [stream_pkg::keep_bits-1:0] s_tkeep  [cred_pkg::n_dests],
  input  logic [stream_pkg::data_bits-1:0] m_tdata,
  input  logic [stream_pkg::keep_bits-1:0] m_tkeep,
  output int                               err_cnt, pkt_cnt, beat_cnt,
  output logic                             idle      // every accepted input has been matched
);

  // ------------------------------------------------------------------------
  // model state, all destinations in one queue each and searched by dest
  // ------------------------------------------------------------------------
  logic [cred_pkg::dest_bits-1:0] pk_dest [$];
  logic [cred_pkg::addr_bits-1:0] pk_addr [$];
  logic [cred_pkg::len_bits-1:0]  pk_len  [$];
  logic [cred_pkg::dest_bits-1:0] bt_dest [$];
  logic [stream_pkg::data_bits+stream_pkg::keep_bits-1:0] bt_word [$];  // tdata over tkeep
  int so_dest  [$];                  // packets whose request went out, oldest streams first
  int so_beats [$];
  int acc      [cred_pkg::n_dests];  // beats accepted on each input stream
  int claimed  [cred_pkg::n_dests];  // beats owned by packets already requested
  int errs, pkts, beats_seen, so_idx;
  bit in_rst;                        // reset seen at the previous edge
  logic idle_q = 1'b1;

  assign err_cnt  = errs;
  assign pkt_cnt  = pkts;
  assign beat_cnt = beats_seen;
  assign idle     = idle_q;

  task automatic flag_mismatch(input string msg);
    $display("Fail %0d ns: %s", $time, msg);
    errs++;
  endtask

  task automatic note_error(input string msg);
    $display("%s at %0d ns", msg, $time);
    errs++;
  endtask

  // a partial beat still takes a whole beat on the stream
  function automatic int beats_of(input int len);
    return (len + stream_pkg::beat_bytes - 1) / stream_pkg::beat_bytes;
  endfunction

  function automatic int first_pkt(input int d);
    for (int i = 0; i < pk_dest.size(); i++) if (pk_dest[i] == d) return i;
    return -1;
  endfunction

  function automatic int first_beat(input int d);
    for (int i = 0; i < bt_dest.size(); i++) if (bt_dest[i] == d) return i;
    return -1;
  endfunction

  always @(posedge aclk) begin
    int i;
    int d;
    int nb;
    logic low;
    logic [cred_pkg::len_bits-1:0]  rem;
    logic [cred_pkg::len_bits-1:0]  l;
    logic [cred_pkg::addr_bits-1:0] a;
    if (!arst_n || in_rst) begin                // in reset and one edge past it
      low = !req_ready && !m_req_valid && !m_tvalid;
      for (int k = 0; k < cred_pkg::n_dests; k++) low = low && !s_tready[k];
      if (!low) flag_mismatch("handshake outputs not low around reset");
    end
    in_rst = !arst_n;
    if (arst_n) begin
      if (req_valid && req_ready) begin        // cut the request into transfer units
        rem = req_len;
        a   = req_addr;
        while (rem != 0) begin
          l = (rem > cred_pkg::pmtu_bytes) ? cred_pkg::pmtu_bytes : rem;
          pk_dest.push_back(req_dest);
          pk_addr.push_back(a);
          pk_len.push_back(l);
          a   = a + l;
          rem = rem - l;
        end
      end
      for (int k = 0; k < cred_pkg::n_dests; k++) begin
        if (s_tvalid[k] && s_tready[k]) begin
          bt_dest.push_back(k);
          bt_word.push_back({s_tdata[k], s_tkeep[k]});
          acc[k]++;
        end
      end
      if (m_req_valid && m_req_ready) begin
        d  = m_req_dest;
        nb = beats_of(m_req_len);
        i  = first_pkt(d);
        pkts++;
        if (i < 0) note_error($sformatf("request for dest %0d with nothing expected", d));
        else begin
          if (m_req_addr != pk_addr[i] || m_req_len != pk_len[i])
            flag_mismatch($sformatf("dest %0d got addr %h len %0d, expected addr %h len %0d",
                                    d, m_req_addr, m_req_len, pk_addr[i], pk_len[i]));
          pk_dest.delete(i);
          pk_addr.delete(i);
          pk_len.delete(i);
        end
        if (m_req_len == 0 || m_req_len > cred_pkg::pmtu_bytes)
          flag_mismatch($sformatf("packet length %0d out of range", m_req_len));
        if (acc[d] < claimed[d] + nb)             // its beats must all be buffered already
          flag_mismatch($sformatf("dest %0d released with %0d of %0d beats buffered",
                                  d, acc[d] - claimed[d], nb));
        claimed[d] += nb;
        so_dest.push_back(d);
        so_beats.push_back(nb);
      end
      if (m_tvalid && m_tready) begin
        beats_seen++;
        if (so_dest.size() == 0) note_error("output beat with no packet request before it");
        else begin
          i = first_beat(so_dest[0]);
          if (i < 0) note_error($sformatf("output beat for dest %0d never sent in", so_dest[0]));
          else begin
            if ({m_tdata, m_tkeep} != bt_word[i])
              flag_mismatch($sformatf("dest %0d beat %h/%h, expected %h", so_dest[0],
                                      m_tdata, m_tkeep, bt_word[i]));
            bt_dest.delete(i);
            bt_word.delete(i);
          end
          if (m_tlast != (so_idx == so_beats[0] - 1))
            flag_mismatch($sformatf("tlast %0b on beat %0d of %0d", m_tlast, so_idx,
                                    so_beats[0]));
          so_idx++;
          if (so_idx == so_beats[0]) begin   // packet framed, next grant takes over
            so_idx = 0;
            so_dest.delete(0);
            so_beats.delete(0);
          end
        end
      end
    end
    idle_q = (pk_dest.size() == 0) && (bt_dest.size() == 0) && (so_dest.size() == 0);
  end

endmodule

//--- tb_host_wr.sv
`timescale 1ns/1ps

module tb_host_wr;

  localparam int total_reqs = 16 + 12 + 24;  // requests over the three traffic tests

  logic                             aclk = 1'b0;
  logic                             arst_n;
  logic                             req_valid, req_ready, m_req_valid, m_req_ready;
  logic                             m_tvalid, m_tready, m_tlast;
  logic [cred_pkg::addr_bits-1:0]   req_addr, m_req_addr;
  logic [cred_pkg::len_bits-1:0]    req_len, m_req_len;
  logic [cred_pkg::dest_bits-1:0]   req_dest, m_req_dest;
  logic                             s_tvalid [cred_pkg::n_dests];
  logic                             s_tready [cred_pkg::n_dests];
  logic [stream_pkg::data_bits-1:0] s_tdata  [cred_pkg::n_dests];
  logic [stream_pkg::keep_bits-1:0] s_tkeep  [cred_pkg::n_dests];
  logic [stream_pkg::data_bits-1:0] m_tdata;
  logic [stream_pkg::keep_bits-1:0] m_tkeep;
  logic [31:0]                      lfsr = 32'h8620;
  logic                             req_fire;                  // handshakes of the last edge
  logic                             s_fire   [cred_pkg::n_dests];
  int                               due      [cred_pkg::n_dests];  // beats a producer owes
  int                               owed, sent, last_errs;
  int                               err_cnt, pkt_cnt, beat_cnt;
  logic                             chk_idle;

  always #5 aclk = ~aclk;

  host_wr_credits DUT (.*);
  tb_checker chk (.*, .idle(chk_idle));

  always @(posedge aclk) begin
    req_fire = req_valid && req_ready;
    for (int d = 0; d < cred_pkg::n_dests; d++) s_fire[d] = s_tvalid[d] && s_tready[d];
  end

  // fibonacci LFSR with taps 32 22 2 1, one step per bit handed out
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[62:0], fb};
    end
    return r;
  endfunction

  // ------------------------------------------------------------------------
  // traffic of n_reqs requests, dest 0 data held back for hold_cyc cycles
  // ------------------------------------------------------------------------
  task automatic run_traffic(input int n_reqs, input bit bp, input int hold_cyc);
    int          left;
    int          cyc;
    logic [63:0] r;
    left = n_reqs;
    cyc  = 0;
    while (left > 0 || req_valid || owed != 0 || !chk_idle) begin
      @(negedge aclk);
      cyc++;
      m_req_ready = bp ? (rand_bits(1) != 0) : 1'b1;
      m_tready    = bp ? (rand_bits(1) != 0) : 1'b1;
      if (req_fire) req_valid = 1'b0;
      if (!req_valid && left > 0 && rand_bits(2) != 0) begin
        r         = rand_bits(1 + 10 + cred_pkg::addr_bits);
        req_addr  = r[cred_pkg::addr_bits-1:0];
        req_len   = r[cred_pkg::addr_bits +: 10] + 1;  // 1 to 1024 bytes
        req_dest  = r[cred_pkg::addr_bits + 10];
        req_valid = 1'b1;
        due[req_dest] += (req_len + stream_pkg::beat_bytes - 1) / stream_pkg::beat_bytes;
        owed += (req_len + stream_pkg::beat_bytes - 1) / stream_pkg::beat_bytes;
        left--;
        sent++;
      end
      for (int d = 0; d < cred_pkg::n_dests; d++) begin
        if (s_fire[d]) begin
          s_tvalid[d] = 1'b0;
          due[d]--;
          owed--;
        end
        if (!s_tvalid[d] && due[d] > 0 && (d != 0 || cyc > hold_cyc) && rand_bits(2) != 0) begin
          s_tdata[d]  = rand_bits(stream_pkg::data_bits);
          r           = rand_bits(stream_pkg::keep_bits);
          s_tkeep[d]  = r[stream_pkg::keep_bits-1:0];
          s_tvalid[d] = 1'b1;
        end
      end
    end
  endtask

  task automatic report_test(input string name);
    $display("%-22s %s, %0d new errors", name, (err_cnt == last_errs) ? "passed" : "failed",
             err_cnt - last_errs);
    last_errs = err_cnt;
  endtask

  initial begin
    arst_n      = 1'b0;
    req_valid   = 1'b0;
    req_addr    = '0;
    req_len     = '0;
    req_dest    = '0;
    m_req_ready = 1'b0;
    m_tready    = 1'b0;
    for (int d = 0; d < cred_pkg::n_dests; d++) begin
      s_tvalid[d] = 1'b0;
      s_tdata[d]  = '0;
      s_tkeep[d]  = '0;
    end
    repeat (4) @(negedge aclk);
    arst_n = 1'b1;
    @(negedge aclk);                         // the checker looks at this first edge too
    report_test("reset");
    run_traffic(16, 1'b0, 0);
    report_test("split and data order");
    run_traffic(12, 1'b0, 300);
    report_test("credit hold");
    run_traffic(24, 1'b1, 0);
    report_test("back-pressure");
    $display("requests %0d, packets %0d, beats %0d, errors %0d", sent, pkt_cnt, beat_cnt,
             err_cnt);
    if (err_cnt == 0) $display("No errors");
    else $display("Errors found");
    $finish;
  end

  // every request may take up to 1024 cycles to drain
  initial begin
    #(total_reqs * 1024 * 10);
    $display("run timed out after %0d cycles without draining", total_reqs * 1024);
    $display("Errors found");
    $finish;
  end

endmodule
